//--- Bender.yml
package:
  name: cpu16

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/cpu16Pkg.sv
      - design/regBlock.sv
      - design/alu.sv
      - design/datapath.sv
      - design/controller.sv
      - design/memPort.sv
      - design/cpu16Top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/cpu16MemModel.sv
      - verification/cpu16Tb.sv

//--- cpu16.f
+incdir+include
design/cpu16Pkg.sv
design/regBlock.sv
design/alu.sv
design/datapath.sv
design/controller.sv
design/memPort.sv
design/cpu16Top.sv
verification/cpu16MemModel.sv
verification/cpu16Tb.sv

//--- design/alu.sv
// purely combinational and carry and overflow are only meaningful for add, adc and sub
`include "cpu16_params.svh"
`default_nettype none

module alu(
	input wire [`CPU16_WORD_W-1:0] op1,
	input wire [`CPU16_WORD_W-1:0] op2,
	input wire carryIn,
	input wire cpu16Pkg::aluOp_t aluOp,
	output logic [`CPU16_WORD_W-1:0] result,
	output logic [3:0] flags
);

	import cpu16Pkg::*;

	localparam int wordW = `CPU16_WORD_W;

	logic [wordW:0] sum;        // extra bit holds the carry out
	logic [wordW-1:0] addB;
	logic addCin;
	logic isArith;

	assign isArith = aluOp inside {aluAdd, aluAdc, aluSub};

	// one adder for all three arithmetic ops
	always_comb begin
		addB = op2;
		addCin = 1'b0;
		case (aluOp)
			aluAdc: addCin = carryIn;
			aluSub: begin
				addB = ~op2;          // a - b as a + ~b + 1
				addCin = 1'b1;
			end
			default: addCin = 1'b0;
		endcase
	end

	assign sum = {1'b0, op1} + {1'b0, addB} + {{wordW{1'b0}}, addCin};

	always_comb begin
		case (aluOp)
			aluAdd, aluAdc, aluSub: result = sum[wordW-1:0];
			aluAnd: result = op1 & op2;
			aluOr: result = op1 | op2;
			aluXor: result = op1 ^ op2;
			default: result = op2;    // pass b
		endcase
	end

	always_comb begin
		flags = '0;
		flags[flagZero] = (result == '0);
		flags[flagNeg] = result[wordW-1];
		flags[flagCarry] = isArith & sum[wordW];
		// same operand signs but a different result sign
		flags[flagOvf] = isArith & (op1[wordW-1] == addB[wordW-1])
			& (sum[wordW-1] != op1[wordW-1]);
	end

endmodule

`default_nettype wire

//--- design/controller.sv
// LDW takes seven cycles and STW six, unknown opcodes act as no-ops and only reset leaves HALT
`include "cpu16_params.svh"
`default_nettype none

module controller(
	input wire Clock,
	input wire rstN,
	ctrlIf.controller ctrl,
	memIf.controller mem,
	output logic halted
);

	import cpu16Pkg::*;

	typedef enum logic [2:0] {
		sFetch, sWait, sDecode, sExec, sMem, sMemWait, sLoad, sHalt
	} state_t;

	state_t state, nextState;
	logic [3:0] flagsReg;
	opcode_t op;
	logic isAluOp;
	logic isMemOp;

	function automatic aluOp_t toAluOp(input opcode_t code);
		case (code)
			opAdc: return aluAdc;
			opSub: return aluSub;
			opAnd: return aluAnd;
			opOr: return aluOr;
			opXor: return aluXor;
			default: return aluAdd;
		endcase
	endfunction

	assign op = ctrl.opcode;
	assign isAluOp = op inside {opAdd, opAdc, opSub, opAnd, opOr, opXor, opAddi};
	assign isMemOp = op inside {opLdw, opStw};
	assign halted = (state == sHalt);
	assign ctrl.carryIn = flagsReg[flagCarry];

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= sFetch;
			flagsReg <= '0;
		end else begin
			state <= nextState;
			// movi and branches leave the flags alone
			if (state == sExec && isAluOp) flagsReg <= ctrl.flags;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			sFetch: nextState = sWait;
			sWait: nextState = sDecode;
			sDecode: nextState = sExec;
			sExec: begin
				if (isMemOp) nextState = sMem;
				else if (op == opHalt) nextState = sHalt;
				else nextState = sFetch;
			end
			sMem: nextState = sMemWait;
			sMemWait: nextState = (op == opLdw) ? sLoad : sFetch;
			sLoad: nextState = sFetch;
			sHalt: nextState = sHalt;
		endcase
	end

	always_comb begin
		ctrl.pcSel = pcIncr;
		ctrl.op1Sel = op1Rd1;
		ctrl.op2Sel = op2Zero;
		ctrl.immSel = immShort;
		ctrl.wdSel = wdAlu;
		ctrl.rs2Sel = rsRb;
		ctrl.rwSel = rwRd;
		ctrl.lrSel = lrBus;
		ctrl.busSel = busMem;
		ctrl.aluOp = aluAdd;
		ctrl.pcWe = 1'b0;
		ctrl.lrWe = 1'b0;
		ctrl.irWe = 1'b0;
		ctrl.regWe = 1'b0;
		ctrl.aluWe = 1'b0;
		mem.rdReq = 1'b0;
		mem.wrReq = 1'b0;
		mem.dataAcc = 1'b0;
		case (state)
			sFetch: mem.rdReq = 1'b1;      // address from pc
			sDecode: begin
				ctrl.irWe = 1'b1;
				ctrl.pcWe = 1'b1;
			end
			sExec: begin
				case (op)
					opAdd, opAdc, opSub, opAnd, opOr, opXor: begin
						ctrl.op2Sel = op2Rd2;
						ctrl.aluOp = toAluOp(op);
						ctrl.regWe = 1'b1;
					end
					opAddi: begin
						ctrl.op2Sel = op2Imm;
						ctrl.regWe = 1'b1;
					end
					opMovi: begin
						ctrl.op2Sel = op2Imm;
						ctrl.immSel = immLong;
						ctrl.aluOp = aluPassB;
						ctrl.rwSel = rwSeven;
						ctrl.regWe = 1'b1;
					end
					opLdw, opStw: begin
						ctrl.op2Sel = op2Imm;   // ra + imm5 into alu output register
						ctrl.aluWe = 1'b1;
					end
					opJmp, opBeq, opBl: begin
						ctrl.op1Sel = op1Pc;
						ctrl.op2Sel = op2Imm;
						ctrl.immSel = immLong;
						ctrl.pcSel = pcAluRes;
						ctrl.pcWe = (op != opBeq) || flagsReg[flagZero];
						ctrl.lrWe = (op == opBl);
						ctrl.busSel = busPc;    // pc already points past the bl
					end
					opRet: begin
						ctrl.pcSel = pcLr;
						ctrl.pcWe = 1'b1;
					end
					default: ctrl.pcWe = 1'b0;
				endcase
			end
			sMem: begin
				mem.dataAcc = 1'b1;
				mem.rdReq = (op == opLdw);
				mem.wrReq = (op == opStw);
				ctrl.rs2Sel = rsRd;
			end
			sLoad: begin
				ctrl.wdSel = wdSys;
				ctrl.regWe = 1'b1;
			end
			default: ctrl.pcWe = 1'b0;
		endcase
	end

	// a bus write into IR or a register takes the memory word read two cycles earlier
	assert property (@(posedge Clock) disable iff (!rstN)
		(ctrl.irWe || (ctrl.regWe && ctrl.wdSel == wdSys))
			|-> ctrl.busSel == busMem && $past(mem.rdReq, 2));

endmodule

`default_nettype wire

//--- design/cpu16Pkg.sv
// encodings assume rd in ir[10:8], ra in ir[7:5], rb in ir[4:2], imm5 in ir[4:0], imm8 in ir[7:0]
`include "cpu16_params.svh"
`default_nettype none

package cpu16Pkg;

	// opcode in ir[15:11], branch offsets count from the next instruction
	typedef enum logic [4:0] {
		opAdd  = 5'h00,     // rd = ra + rb
		opAdc  = 5'h01,     // rd = ra + rb + carry
		opSub  = 5'h02,
		opAnd  = 5'h03,
		opOr   = 5'h04,
		opXor  = 5'h05,
		opAddi = 5'h06,     // rd = ra + imm5
		opMovi = 5'h07,     // r7 = imm8
		opLdw  = 5'h08,     // rd = mem[ra + imm5]
		opStw  = 5'h09,     // mem[ra + imm5] = rd
		opJmp  = 5'h0A,
		opBeq  = 5'h0B,
		opBl   = 5'h0C,
		opRet  = 5'h0D,
		opHalt = 5'h1F
	} opcode_t;

	typedef enum logic [2:0] {aluAdd, aluAdc, aluSub, aluAnd, aluOr, aluXor, aluPassB} aluOp_t;

	typedef enum logic [1:0] {pcIncr, pcLr, pcAluRes, pcBus} pcSel_t;
	typedef enum logic {op1Rd1, op1Pc} op1Sel_t;
	typedef enum logic [1:0] {op2Rd2, op2Imm, op2Zero} op2Sel_t;
	typedef enum logic {immShort, immLong} immSel_t;   // imm5 or imm8
	typedef enum logic {wdAlu, wdSys} wdSel_t;
	typedef enum logic {rsRb, rsRd} rsSel_t;           // second read port field
	typedef enum logic {rwRd, rwSeven} rwSel_t;
	typedef enum logic {lrPcIncr, lrBus} lrSel_t;
	typedef enum logic [1:0] {busMem, busPc, busLr, busAluOut} busSel_t;

	// bit positions in the flag word
	localparam int flagZero  = 0;
	localparam int flagCarry = 1;
	localparam int flagNeg   = 2;
	localparam int flagOvf   = 3;

endpackage

interface ctrlIf;
	import cpu16Pkg::*;
	pcSel_t pcSel;
	op1Sel_t op1Sel;
	op2Sel_t op2Sel;
	immSel_t immSel;
	wdSel_t wdSel;
	rsSel_t rs2Sel;
	rwSel_t rwSel;
	lrSel_t lrSel;
	busSel_t busSel;
	aluOp_t aluOp;
	logic carryIn;
	logic pcWe, lrWe, irWe, regWe, aluWe;
	opcode_t opcode;
	logic [3:0] flags;          // straight from the alu, not stored

	modport controller(output pcSel, op1Sel, op2Sel, immSel, wdSel, rs2Sel, rwSel, lrSel,
		busSel, aluOp, carryIn, pcWe, lrWe, irWe, regWe, aluWe, input opcode, flags);
	modport datapath(input pcSel, op1Sel, op2Sel, immSel, wdSel, rs2Sel, rwSel, lrSel,
		busSel, aluOp, carryIn, pcWe, lrWe, irWe, regWe, aluWe, output opcode, flags);
endinterface

interface memIf;
	logic [`CPU16_WORD_W-1:0] addrSrc;
	logic [`CPU16_WORD_W-1:0] storeData;
	logic [`CPU16_WORD_W-1:0] busIn;
	logic rdReq;
	logic wrReq;
	logic dataAcc;              // address from alu output register instead of pc

	modport controller(output rdReq, wrReq, dataAcc);
	modport datapath(output addrSrc, storeData, input busIn, dataAcc);
	modport memPort(input addrSrc, storeData, rdReq, wrReq, output busIn);
endinterface

`default_nettype wire

//--- design/cpu16Top.sv
// expects a single-port word memory that answers one cycle after memRd with no wait states
`include "cpu16_params.svh"
`default_nettype none

module cpu16Top(
	input wire Clock,
	input wire rstN,
	output wire [`CPU16_WORD_W-1:0] memAddr,
	output wire [`CPU16_WORD_W-1:0] memWData,
	output wire memRd,
	output wire memWr,
	input wire [`CPU16_WORD_W-1:0] memRData,
	output wire halted
);

	ctrlIf ctrlBus();
	memIf memBus();

	controller ctrlInst(
		.Clock  (Clock),
		.rstN   (rstN),
		.ctrl   (ctrlBus.controller),
		.mem    (memBus.controller),
		.halted (halted)
	);

	datapath dpInst(
		.Clock (Clock),
		.rstN  (rstN),
		.ctrl  (ctrlBus.datapath),
		.mem   (memBus.datapath)
	);

	memPort memInst(
		.Clock    (Clock),
		.rstN     (rstN),
		.mem      (memBus.memPort),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memRd    (memRd),
		.memWr    (memWr),
		.memRData (memRData)
	);

endmodule

`default_nettype wire

//--- design/datapath.sv
// the shared bus is a driver-select mux with one driver per cycle and it has no real tristates
`include "cpu16_params.svh"
`default_nettype none

module datapath(
	input wire Clock,
	input wire rstN,
	ctrlIf.datapath ctrl,
	memIf.datapath mem
);

	import cpu16Pkg::*;

	localparam int wordW = `CPU16_WORD_W;

	logic [wordW-1:0] sysBus;
	logic [wordW-1:0] pc, pcIn, pcNext;
	logic [wordW-1:0] lr, lrIn;
	logic [wordW-1:0] ir;
	logic [wordW-1:0] aluOut, aluRes;
	logic [wordW-1:0] op1, op2, extended;
	logic [wordW-1:0] wData, rd1, rd2;
	logic [2:0] rs2, rw;

	assign pcNext = pc + 1'b1;
	assign ctrl.opcode = opcode_t'(ir[15:11]);

	// sign extend imm5 or imm8
	assign extended = (ctrl.immSel == immShort) ? {{(wordW-5){ir[4]}}, ir[4:0]}
		: {{(wordW-8){ir[7]}}, ir[7:0]};

	always_comb begin
		case (ctrl.busSel)
			busMem: sysBus = mem.busIn;
			busPc: sysBus = pc;
			busLr: sysBus = lr;
			default: sysBus = aluOut;
		endcase
	end

	assign wData = (ctrl.wdSel == wdSys) ? sysBus : aluRes;
	assign lrIn = (ctrl.lrSel == lrPcIncr) ? pcNext : sysBus;
	assign rs2 = (ctrl.rs2Sel == rsRd) ? ir[10:8] : ir[4:2];    // rd is the store source
	assign rw = (ctrl.rwSel == rwSeven) ? 3'(`CPU16_NREGS - 1) : ir[10:8];

	always_comb begin
		case (ctrl.pcSel)
			pcLr: pcIn = lr;
			pcAluRes: pcIn = aluRes;
			pcBus: pcIn = sysBus;
			default: pcIn = pcNext;
		endcase
	end

	assign op1 = (ctrl.op1Sel == op1Pc) ? pc : rd1;

	always_comb begin
		case (ctrl.op2Sel)
			op2Rd2: op2 = rd2;
			op2Imm: op2 = extended;
			default: op2 = '0;
		endcase
	end

	// data accesses use the address latched in the alu output register
	assign mem.addrSrc = mem.dataAcc ? aluOut : pc;
	assign mem.storeData = rd2;

	regBlock regs(
		.Clock (Clock),
		.rstN  (rstN),
		.rs1   (ir[7:5]),
		.rs2   (rs2),
		.rw    (rw),
		.wData (wData),
		.we    (ctrl.regWe),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	alu aluInst(
		.op1     (op1),
		.op2     (op2),
		.carryIn (ctrl.carryIn),
		.aluOp   (ctrl.aluOp),
		.result  (aluRes),
		.flags   (ctrl.flags)
	);

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			pc <= wordW'(`CPU16_RESET_PC);
			ir <= '0;
		end else begin
			if (ctrl.pcWe) pc <= pcIn;
			if (ctrl.irWe) ir <= sysBus;       // fetched word arrives on the bus
		end
	end

	always_ff @(posedge Clock) begin
		if (ctrl.lrWe) lr <= lrIn;
		if (ctrl.aluWe) aluOut <= aluRes;
	end

endmodule

`default_nettype wire

//--- design/memPort.sv
// strobes come one cycle after a request and memRData must be valid the cycle after memRd
`include "cpu16_params.svh"
`default_nettype none

module memPort(
	input wire Clock,
	input wire rstN,
	memIf.memPort mem,
	output logic [`CPU16_WORD_W-1:0] memAddr,
	output logic [`CPU16_WORD_W-1:0] memWData,
	output logic memRd,
	output logic memWr,
	input wire [`CPU16_WORD_W-1:0] memRData
);

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			memRd <= 1'b0;
			memWr <= 1'b0;
		end else begin
			memRd <= mem.rdReq;     // single cycle pulses
			memWr <= mem.wrReq;
		end
	end

	// address and data held until the next request
	always_ff @(posedge Clock) begin
		if (mem.rdReq || mem.wrReq) memAddr <= mem.addrSrc;
		if (mem.wrReq) memWData <= mem.storeData;
	end

	assign mem.busIn = memRData;

	// single-port memory
	assert property (@(posedge Clock) disable iff (!rstN) !(memRd && memWr));

endmodule

`default_nettype wire

//--- design/regBlock.sv
// registers clear on reset and a write shows on the read ports only after the clock edge
`include "cpu16_params.svh"
`default_nettype none

module regBlock(
	input wire Clock,
	input wire rstN,
	input wire [2:0] rs1,
	input wire [2:0] rs2,
	input wire [2:0] rw,
	input wire [`CPU16_WORD_W-1:0] wData,
	input wire we,
	output logic [`CPU16_WORD_W-1:0] rd1,
	output logic [`CPU16_WORD_W-1:0] rd2
);

	logic [`CPU16_WORD_W-1:0] regs [`CPU16_NREGS];

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU16_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rw] <= wData;
		end
	end

	// both read ports are plain muxes
	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

endmodule

`default_nettype wire

//--- include/cpu16_params.svh
// word width is also the address width and the memory is word addressed
`ifndef CPU16_PARAMS_SVH
`define CPU16_PARAMS_SVH

// data and address width
`define CPU16_WORD_W 16

// register count, the last register is the MOVI target
`define CPU16_NREGS 8

// first fetch address after reset
`define CPU16_RESET_PC 'h0000

`endif

//--- verification/cpu16MemModel.sv
// covers the full 16-bit word address space, reads answer one cycle after rd with no wait states
`include "cpu16_params.svh"
`default_nettype none

module cpu16MemModel(
	input wire Clock,
	input wire [`CPU16_WORD_W-1:0] addr,
	input wire [`CPU16_WORD_W-1:0] wData,
	input wire rd,
	input wire wr,
	output logic [`CPU16_WORD_W-1:0] rData
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int depth = 1 << `CPU16_WORD_W;

	logic [`CPU16_WORD_W-1:0] words [depth];

	initial begin
		rData = '0;
	end

	// strobes are sampled on the edge that ends their cycle
	always @(posedge Clock) begin
		if (wr) begin
			words[addr] <= wData;
		end
		if (rd) begin
			rData <= words[addr];     // valid through the following cycle
		end
	end

	// byte swap plus a constant, so every address bit shows in the word
	function automatic logic [`CPU16_WORD_W-1:0] patternAt(input logic [`CPU16_WORD_W-1:0] a);
		return {a[7:0], a[15:8]} ^ 16'hC3A5;
	endfunction

	task automatic fillAll();
		for (int i = 0; i < depth; i++) begin
			words[i] = patternAt(16'(i));
		end
	endtask

	task automatic writeWord(input logic [`CPU16_WORD_W-1:0] a,
		input logic [`CPU16_WORD_W-1:0] value);
		words[a] = value;
	endtask

	function automatic logic [`CPU16_WORD_W-1:0] readWord(input logic [`CPU16_WORD_W-1:0] a);
		return words[a];
	endfunction

endmodule

`default_nettype wire

//--- verification/cpu16Tb.sv
// programs are hand assembled into the memory model and every test restarts the CPU from reset
`include "cpu16_params.svh"
`default_nettype none

module cpu16Tb;
	timeunit 1ns;
	timeprecision 1ps;

	import cpu16Pkg::*;

	localparam int period = 40;
	localparam int driveDelay = 2;
	localparam int waitLimit = 500;   // cycles

	logic Clock;
	logic rstN;
	wire [`CPU16_WORD_W-1:0] memAddr;
	wire [`CPU16_WORD_W-1:0] memWData;
	wire [`CPU16_WORD_W-1:0] memRData;
	wire memRd;
	wire memWr;
	wire halted;
	logic [15:0] loadAddr;

	cpu16Top dut_i(
		.Clock    (Clock),
		.rstN     (rstN),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memRd    (memRd),
		.memWr    (memWr),
		.memRData (memRData),
		.halted   (halted)
	);

	cpu16MemModel memInst(
		.Clock (Clock),
		.addr  (memAddr),
		.wData (memWData),
		.rd    (memRd),
		.wr    (memWr),
		.rData (memRData)
	);

	initial begin
		Clock = 1'b0;
		forever #(period / 2) Clock = ~Clock;
	end

	// instruction formats: op | rd | ra | rb | 00, op | rd | ra | imm5, op | 000 | imm8
	function automatic logic [15:0] regInstr(opcode_t op, int rd, int ra, int rb);
		return {op, 3'(rd), 3'(ra), 3'(rb), 2'b00};
	endfunction

	function automatic logic [15:0] shortImmInstr(opcode_t op, int rd, int ra, int imm5);
		return {op, 3'(rd), 3'(ra), 5'(imm5)};
	endfunction

	function automatic logic [15:0] longImmInstr(opcode_t op, int imm8);
		return {op, 3'b000, 8'(imm8)};
	endfunction

	task automatic nextCycle();
		@(posedge Clock);
		#driveDelay;                    // outputs settled, inputs change here
	endtask

	task automatic abortRun();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic checkValues(input string testName, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual) begin
			$display("error %s: expected %h, actual %h", testName, expected, actual);
			abortRun();
		end
	endtask

	task automatic emit(input logic [15:0] word);
		memInst.writeWord(loadAddr, word);
		loadAddr = loadAddr + 1'b1;
	endtask

	task automatic startProgram();
		rstN = 1'b0;
		memInst.fillAll();
		loadAddr = `CPU16_RESET_PC;
	endtask

	task automatic releaseReset();
		repeat (5) nextCycle();
		rstN = 1'b1;
	endtask

	task automatic waitHalted(input string testName);
		int cycles;
		cycles = 0;
		while (halted !== 1'b1) begin
			if (cycles == waitLimit) begin
				$display("%s: the CPU did not halt within %0d cycles", testName, waitLimit);
				abortRun();
			end
			nextCycle();
			cycles++;
		end
	endtask

	task automatic waitMemRd(input string testName);
		int cycles;
		cycles = 0;
		while (memRd !== 1'b1) begin
			if (cycles == waitLimit) begin
				$display("%s: no memory read within %0d cycles", testName, waitLimit);
				abortRun();
			end
			nextCycle();
			cycles++;
		end
	endtask

	task automatic testReset();
		string name;
		name = "reset";
		startProgram();
		emit(longImmInstr(opHalt, 0));
		repeat (5) begin
			nextCycle();
			checkValues(name, 16'd0, {15'd0, memRd});
			checkValues(name, 16'd0, {15'd0, memWr});
			checkValues(name, 16'd0, {15'd0, halted});
		end
		rstN = 1'b1;
		waitMemRd(name);
		checkValues(name, `CPU16_RESET_PC, memAddr);   // first fetch
		waitHalted(name);
	endtask

	task automatic testAlu();
		opcode_t regOps [5] = '{opAdd, opSub, opAnd, opOr, opXor};
		logic [15:0] a, b, c, d;
		logic [15:0] expected [9];
		logic [7:0] imm8;
		int negImm;
		a = 16'($urandom);
		b = 16'($urandom);
		c = 16'($urandom) | 16'h8000;   // c + d always carries out
		d = 16'($urandom) | 16'h8000;
		imm8 = 8'($urandom);
		negImm = -1 - int'($urandom % 16);
		expected = '{a + b, a - b, a & b, a | b, a ^ b, a + 16'(negImm),
			{{8{imm8[7]}}, imm8}, c + d, a + b + 16'd1};
		startProgram();
		memInst.writeWord(16'h0040, a);
		memInst.writeWord(16'h0041, b);
		memInst.writeWord(16'h0042, c);
		memInst.writeWord(16'h0043, d);
		emit(longImmInstr(opMovi, 8'h40));
		emit(shortImmInstr(opAddi, 6, 7, 0));      // r6 operand base
		emit(longImmInstr(opMovi, 8'h60));
		emit(shortImmInstr(opAddi, 5, 7, 0));      // r5 result base
		for (int k = 1; k <= 4; k++) begin
			emit(shortImmInstr(opLdw, k, 6, k - 1));
		end
		for (int k = 0; k < 5; k++) begin
			emit(regInstr(regOps[k], 0, 1, 2));
			emit(shortImmInstr(opStw, 0, 5, k));
		end
		emit(shortImmInstr(opAddi, 0, 1, negImm));
		emit(shortImmInstr(opStw, 0, 5, 5));
		emit(longImmInstr(opMovi, imm8));
		emit(shortImmInstr(opStw, 7, 5, 6));
		emit(regInstr(opAdd, 0, 3, 4));            // sets the carry
		emit(shortImmInstr(opStw, 0, 5, 7));
		emit(regInstr(opAdc, 0, 1, 2));
		emit(shortImmInstr(opStw, 0, 5, 8));
		emit(longImmInstr(opHalt, 0));
		releaseReset();
		waitHalted("alu");
		for (int k = 0; k < 9; k++) begin
			checkValues($sformatf("alu result %0d", k), expected[k],
				memInst.readWord(16'(16'h0060 + k)));
		end
	endtask

	task automatic testLoadStore();
		logic [15:0] w0, w1;
		w0 = 16'($urandom);
		w1 = 16'($urandom);
		startProgram();
		memInst.writeWord(16'h0042, w0);
		memInst.writeWord(16'h004A, w1);
		emit(longImmInstr(opMovi, 8'h40));
		emit(shortImmInstr(opAddi, 1, 7, 3));      // r1 = 0x43
		emit(longImmInstr(opMovi, 8'h50));
		emit(shortImmInstr(opAddi, 2, 7, -2));     // r2 = 0x4e
		emit(shortImmInstr(opLdw, 3, 1, -1));
		emit(shortImmInstr(opStw, 3, 2, 5));
		emit(shortImmInstr(opLdw, 4, 1, 7));
		emit(shortImmInstr(opStw, 4, 2, -6));
		emit(longImmInstr(opHalt, 0));
		releaseReset();
		waitHalted("load store");
		checkValues("load store", w0, memInst.readWord(16'h0053));
		checkValues("load store", w1, memInst.readWord(16'h0048));
		checkValues("load store", w0, memInst.readWord(16'h0042));
	endtask

	task automatic testBranch();
		string name;
		name = "branch";
		startProgram();
		emit(longImmInstr(opMovi, 8'h60));
		emit(shortImmInstr(opAddi, 6, 7, 0));
		emit(regInstr(opSub, 0, 6, 6));            // zero result
		emit(longImmInstr(opBeq, 2));              // taken, to 6
		emit(longImmInstr(opMovi, 8'h11));
		emit(shortImmInstr(opStw, 7, 6, 0));
		emit(longImmInstr(opMovi, 8'h22));
		emit(shortImmInstr(opStw, 7, 6, 1));
		emit(shortImmInstr(opAddi, 0, 6, 1));      // nonzero result
		emit(longImmInstr(opBeq, 2));              // falls through
		emit(longImmInstr(opMovi, 8'h33));
		emit(shortImmInstr(opStw, 7, 6, 2));
		emit(longImmInstr(opJmp, 2));              // to 15
		emit(longImmInstr(opMovi, 8'h44));
		emit(shortImmInstr(opStw, 7, 6, 3));
		emit(longImmInstr(opMovi, 8'h55));
		emit(shortImmInstr(opStw, 7, 6, 4));
		emit(longImmInstr(opHalt, 0));
		releaseReset();
		waitHalted(name);
		checkValues(name, memInst.patternAt(16'h0060), memInst.readWord(16'h0060));
		checkValues(name, 16'h0022, memInst.readWord(16'h0061));
		checkValues(name, 16'h0033, memInst.readWord(16'h0062));
		checkValues(name, memInst.patternAt(16'h0063), memInst.readWord(16'h0063));
		checkValues(name, 16'h0055, memInst.readWord(16'h0064));
	endtask

	task automatic testCall();
		startProgram();
		emit(longImmInstr(opMovi, 8'h60));
		emit(shortImmInstr(opAddi, 6, 7, 0));
		emit(longImmInstr(opBl, 3));               // lr = 3, to 6
		emit(longImmInstr(opMovi, 8'h66));         // return lands here
		emit(shortImmInstr(opStw, 7, 6, 1));
		emit(longImmInstr(opHalt, 0));
		emit(longImmInstr(opMovi, 8'h77));         // subroutine
		emit(shortImmInstr(opStw, 7, 6, 0));
		emit(longImmInstr(opRet, 0));
		releaseReset();
		waitHalted("call");
		checkValues("call", 16'h0077, memInst.readWord(16'h0060));
		checkValues("call", 16'h0066, memInst.readWord(16'h0061));
	endtask

	task automatic testHaltQuiet();
		string name;
		name = "halt";
		startProgram();
		emit(longImmInstr(opMovi, 8'h5A));
		emit(shortImmInstr(opStw, 7, 0, 10));      // r0 still zero
		emit(longImmInstr(opHalt, 0));
		releaseReset();
		waitHalted(name);
		repeat (20) begin
			nextCycle();
			checkValues(name, 16'd0, {15'd0, memRd});
			checkValues(name, 16'd0, {15'd0, memWr});
			checkValues(name, 16'd1, {15'd0, halted});
		end
		checkValues(name, 16'h005A, memInst.readWord(16'h000A));
	endtask

	initial begin
		rstN = 1'b0;
		loadAddr = '0;
		void'($urandom(13));
		testReset();
		testAlu();
		testLoadStore();
		testBranch();
		testCall();
		testHaltQuiet();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire
